// ==== Bender.yml ====
package:
  name: threefish

sources:
  - rtl/threefish_pkg.sv
  - rtl/tf_round_counter.sv
  - rtl/tf_control_fsm.sv
  - rtl/tf_key_schedule.sv
  - rtl/tf_mix_datapath.sv
  - rtl/threefish_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/threefish_tb.sv

// ==== filelist.f ====
rtl/threefish_pkg.sv
rtl/tf_round_counter.sv
rtl/tf_control_fsm.sv
rtl/tf_key_schedule.sv
rtl/tf_mix_datapath.sv
rtl/threefish_top.sv
sim/tb_clock_gen.sv
sim/threefish_tb.sv

// ==== rtl/tf_control_fsm.sv ====
module tf_control_fsm #(
	parameter int unsigned NUM_ROUNDS = 72
) (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	input  logic                   start_i,
	input  threefish_pkg::tf_pos_t pos_i,
	input  logic                   last_i,
	output logic                   load_o,
	output logic                   inject_o,
	output logic                   mix_o,
	output logic                   finish_o,
	output logic                   done_o,
	output logic                   busy_o
);

	import threefish_pkg::*;

	tf_state_e state_q;
	tf_state_e state_d;
	logic      done_q;

	if (NUM_ROUNDS == 0 || NUM_ROUNDS % 4 != 0 || NUM_ROUNDS > 124) begin : g_bad_rounds
		$error("NUM_ROUNDS must be a nonzero multiple of 4, at most 124");
	end

	// Start is taken only when fully idle.
	assign load_o = (state_q == TF_IDLE) && start_i && !done_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			TF_IDLE: begin
				if (load_o) begin
					state_d = TF_LOAD;
				end
			end
			TF_LOAD:   state_d = TF_INJECT;
			TF_INJECT: state_d = last_i ? TF_DONE : TF_MIX;
			TF_MIX: begin
				if (pos_i.round == 2'd3 && pos_i.pair_sel) begin
					state_d = TF_INJECT; // End of group.
				end
			end
			TF_DONE:   state_d = TF_IDLE;
			default:   state_d = TF_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= TF_IDLE;
			done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			done_q  <= (state_q == TF_DONE); // Lines up with the result write.
		end
	end

	assign inject_o = (state_q == TF_INJECT);
	assign mix_o    = (state_q == TF_MIX);
	assign finish_o = (state_q == TF_DONE);
	assign done_o   = done_q;
	assign busy_o   = (state_q != TF_IDLE) || done_q;

endmodule

// ==== rtl/tf_key_schedule.sv ====
module tf_key_schedule (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  logic                     load_i,
	input  threefish_pkg::tf_block_t key_i,
	input  threefish_pkg::tf_tweak_t tweak_i,
	input  logic [4:0]               subkey_idx_i,
	output threefish_pkg::tf_block_t subkey_o
);

	import threefish_pkg::*;

	tf_word_t [4:0] key_q;
	tf_word_t [2:0] tweak_q;
	logic [2:0]     key_sel [4];
	logic [1:0]     tw_sel_a;
	logic [1:0]     tw_sel_b;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			key_q   <= '0;
			tweak_q <= '0;
		end else if (load_i) begin
			key_q[3:0] <= key_i;
			key_q[4]   <= TF_KEY_PARITY ^ key_i[0] ^ key_i[1] ^ key_i[2] ^ key_i[3];
			tweak_q[0] <= tweak_i[0];
			tweak_q[1] <= tweak_i[1];
			tweak_q[2] <= tweak_i[0] ^ tweak_i[1];
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			key_sel[i] = 3'((32'(subkey_idx_i) + i) % 5);
		end
		tw_sel_a = 2'(32'(subkey_idx_i) % 3);
		tw_sel_b = 2'((32'(subkey_idx_i) + 1) % 3);
	end

	// Subkey words for group s.
	always_comb begin
		subkey_o[0] = key_q[key_sel[0]];
		subkey_o[1] = key_q[key_sel[1]] + tweak_q[tw_sel_a];
		subkey_o[2] = key_q[key_sel[2]] + tweak_q[tw_sel_b];
		subkey_o[3] = key_q[key_sel[3]] + 64'(subkey_idx_i);
	end

endmodule

// ==== rtl/tf_mix_datapath.sv ====
module tf_mix_datapath (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  logic                     load_i,
	input  logic                     inject_i,
	input  logic                     mix_i,
	input  logic                     finish_i,
	input  threefish_pkg::tf_block_t block_i,
	input  threefish_pkg::tf_mode_e  mode_i,
	input  threefish_pkg::tf_block_t subkey_i,
	input  threefish_pkg::tf_pos_t   pos_i,
	output threefish_pkg::tf_block_t result_o
);

	import threefish_pkg::*;

	tf_block_t    state_q;
	tf_block_t    plain_q;
	tf_block_t    result_q;
	tf_mode_e     mode_q;
	tf_block_t    injected;
	tf_rot_t      rot_amt;
	tf_word_t     x0;
	tf_word_t     x1;
	tf_word_t     y0;
	tf_word_t     y1;
	logic [127:0] rot_dbl;

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			injected[i] = state_q[i] + subkey_i[i];
		end
	end

	// One MIX on the selected pair.
	always_comb begin
		rot_amt = tf_rot_const({pos_i.subkey_idx[0], pos_i.round}, pos_i.pair_sel);
		x0      = pos_i.pair_sel ? state_q[2] : state_q[0];
		x1      = pos_i.pair_sel ? state_q[3] : state_q[1];
		rot_dbl = {x1, x1} << rot_amt;
		y0      = x0 + x1;
		y1      = rot_dbl[127:64] ^ y0; // Upper half is the left rotation.
	end

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			state_q <= block_i;
			plain_q <= block_i;
		end else if (inject_i) begin
			state_q <= injected;
		end else if (mix_i) begin
			if (!pos_i.pair_sel) begin
				state_q[0] <= y0;
				state_q[1] <= y1;
			end else begin
				// Permute to 0, 3, 2, 1 on write.
				state_q[1] <= y1;
				state_q[2] <= y0;
				state_q[3] <= state_q[1];
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mode_q   <= TF_ENCRYPT;
			result_q <= '0;
		end else begin
			if (load_i) begin
				mode_q <= mode_i;
			end
			if (finish_i) begin
				result_q <= (mode_q == TF_UBI) ? (state_q ^ plain_q) : state_q;
			end
		end
	end

	assign result_o = result_q;

endmodule

// ==== rtl/tf_round_counter.sv ====
module tf_round_counter #(
	parameter int unsigned NUM_ROUNDS = 72
) (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	input  logic                   clear_i,
	input  logic                   inject_i,
	input  logic                   mix_i,
	output threefish_pkg::tf_pos_t pos_o,
	output logic                   last_o
);

	import threefish_pkg::*;

	localparam logic [4:0] LAST_IDX = 5'(NUM_ROUNDS / 4);

	tf_pos_t pos_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pos_q <= '0;
		end else if (clear_i) begin
			pos_q <= '0;
		end else if (inject_i) begin
			pos_q.round    <= 2'd0;
			pos_q.pair_sel <= 1'b0;
		end else if (mix_i) begin
			pos_q.pair_sel <= ~pos_q.pair_sel;
			if (pos_q.pair_sel) begin
				pos_q.round <= pos_q.round + 2'd1; // Wraps after round 3.
				if (pos_q.round == 2'd3) begin
					pos_q.subkey_idx <= pos_q.subkey_idx + 5'd1;
				end
			end
		end
	end

	assign pos_o = pos_q;

	// Final subkey injection.
	assign last_o = (pos_q.subkey_idx == LAST_IDX);

endmodule

// ==== rtl/threefish_pkg.sv ====
package threefish_pkg;

	typedef logic [63:0] tf_word_t;

	// Word 0 sits in the lowest bits.
	typedef tf_word_t [3:0] tf_block_t;
	typedef tf_word_t [1:0] tf_tweak_t;

	typedef logic [5:0] tf_rot_t;

	typedef enum logic {
		TF_ENCRYPT = 1'b0,
		TF_UBI     = 1'b1
	} tf_mode_e;

	typedef struct packed {
		tf_mode_e  mode;
		tf_block_t key;
		tf_tweak_t tweak;
		tf_block_t block;
	} tf_cmd_t;

	typedef enum logic [2:0] {
		TF_IDLE   = 3'd0,
		TF_LOAD   = 3'd1,
		TF_INJECT = 3'd2,
		TF_MIX    = 3'd3,
		TF_DONE   = 3'd4
	} tf_state_e;

	typedef struct packed {
		logic [4:0] subkey_idx; // Subkey group.
		logic [1:0] round; // Round within group.
		logic       pair_sel; // 0: words 0/1, 1: words 2/3.
	} tf_pos_t;

	localparam tf_word_t TF_KEY_PARITY = 64'h1BD1_1BDA_A9FC_1A22;

	// Threefish-256 rotation constants, indexed by round mod 8 and pair.
	function automatic tf_rot_t tf_rot_const(input logic [2:0] rnd, input logic pair);
		tf_rot_t r0;
		tf_rot_t r1;
		case (rnd)
			3'd0: begin
				r0 = 6'd14;
				r1 = 6'd16;
			end
			3'd1: begin
				r0 = 6'd52;
				r1 = 6'd57;
			end
			3'd2: begin
				r0 = 6'd23;
				r1 = 6'd40;
			end
			3'd3: begin
				r0 = 6'd5;
				r1 = 6'd37;
			end
			3'd4: begin
				r0 = 6'd25;
				r1 = 6'd33;
			end
			3'd5: begin
				r0 = 6'd46;
				r1 = 6'd12;
			end
			3'd6: begin
				r0 = 6'd58;
				r1 = 6'd22;
			end
			default: begin
				r0 = 6'd32;
				r1 = 6'd32;
			end
		endcase
		return pair ? r1 : r0;
	endfunction

endpackage

// ==== rtl/threefish_top.sv ====
module threefish_top #(
	parameter int unsigned NUM_ROUNDS = 72
) (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  logic                     start_i,
	input  threefish_pkg::tf_cmd_t   cmd_i,
	output threefish_pkg::tf_block_t result_o,
	output logic                     done_o,
	output logic                     busy_o
);

	import threefish_pkg::*;

	tf_pos_t   pos_w;
	tf_block_t subkey_w;
	logic      last_w;
	logic      load_w;
	logic      inject_w;
	logic      mix_w;
	logic      finish_w;

	tf_round_counter #(
		.NUM_ROUNDS(NUM_ROUNDS)
	) tf_round_counter_inst (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.clear_i(load_w),
		.inject_i(inject_w),
		.mix_i(mix_w),
		.pos_o(pos_w),
		.last_o(last_w)
	);

	tf_control_fsm #(
		.NUM_ROUNDS(NUM_ROUNDS)
	) tf_control_fsm_inst (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.start_i(start_i),
		.pos_i(pos_w),
		.last_i(last_w),
		.load_o(load_w),
		.inject_o(inject_w),
		.mix_o(mix_w),
		.finish_o(finish_w),
		.done_o(done_o),
		.busy_o(busy_o)
	);

	tf_key_schedule tf_key_schedule_inst (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.load_i(load_w),
		.key_i(cmd_i.key),
		.tweak_i(cmd_i.tweak),
		.subkey_idx_i(pos_w.subkey_idx),
		.subkey_o(subkey_w)
	);

	tf_mix_datapath tf_mix_datapath_inst (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.load_i(load_w),
		.inject_i(inject_w),
		.mix_i(mix_w),
		.finish_i(finish_w),
		.block_i(cmd_i.block),
		.mode_i(cmd_i.mode),
		.subkey_i(subkey_w),
		.pos_i(pos_w),
		.result_o(result_o)
	);

endmodule

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		arst_n_o <= 1'b1;
	end

endmodule

// ==== sim/threefish_tb.sv ====
module threefish_tb;

	import threefish_pkg::*;

	localparam int unsigned NUM_ROUNDS = 72;
	localparam int LATENCY        = 2 * NUM_ROUNDS + NUM_ROUNDS / 4 + 3;
	localparam int OP_LIMIT       = LATENCY + 5;
	localparam int TIMEOUT_CYCLES = 12 * OP_LIMIT; // Twelve operations in all.
	localparam int ROT_TABLE [16] = '{14, 16, 52, 57, 23, 40, 5, 37,
		25, 33, 46, 12, 58, 22, 32, 32};

	logic      clk;
	logic      por_n;
	logic      abort_n;
	logic      arst_n;
	logic      start;
	tf_cmd_t   cmd;
	tf_block_t result;
	logic      done;
	logic      busy;
	int        errors       = 0;
	int        tests_run    = 0;
	int        tests_failed = 0;
	int        cycles       = 0;

	assign arst_n = por_n & abort_n; // Power-on reset or mid-run abort.

	tb_clock_gen #(
		.PERIOD(20),
		.RESET_CYCLES(3)
	) tb_clock_gen_inst (
		.clk_o(clk),
		.arst_n_o(por_n)
	);

	threefish_top #(
		.NUM_ROUNDS(NUM_ROUNDS)
	) threefish_top_inst (
		.clk_i(clk),
		.arst_n_i(arst_n),
		.start_i(start),
		.cmd_i(cmd),
		.result_o(result),
		.done_o(done),
		.busy_o(busy)
	);

	function automatic tf_word_t rotl(input tf_word_t x, input int r);
		return (x << r) | (x >> (64 - r));
	endfunction

	// Threefish-256 encryption with subkey injection every four rounds.
	function automatic tf_block_t cipher_ref(input tf_block_t key, input tf_tweak_t tweak,
		input tf_block_t pt);
		tf_word_t  k [5];
		tf_word_t  t [3];
		tf_word_t  y [4];
		tf_block_t v;
		int        s;
		k[4] = TF_KEY_PARITY;
		for (int i = 0; i < 4; i++) begin
			k[i] = key[i];
			k[4] ^= key[i];
		end
		t[0] = tweak[0];
		t[1] = tweak[1];
		t[2] = tweak[0] ^ tweak[1];
		v = pt;
		for (int d = 0; d <= NUM_ROUNDS; d++) begin
			if (d % 4 == 0) begin
				s = d / 4;
				v[0] += k[s % 5];
				v[1] += k[(s + 1) % 5] + t[s % 3];
				v[2] += k[(s + 2) % 5] + t[(s + 1) % 3];
				v[3] += k[(s + 3) % 5] + 64'(s);
			end
			if (d < NUM_ROUNDS) begin
				y[0] = v[0] + v[1];
				y[1] = rotl(v[1], ROT_TABLE[2 * (d % 8)]) ^ y[0];
				y[2] = v[2] + v[3];
				y[3] = rotl(v[3], ROT_TABLE[2 * (d % 8) + 1]) ^ y[2];
				v = {y[1], y[2], y[3], y[0]}; // Words 0, 3, 2, 1.
			end
		end
		return v;
	endfunction

	function automatic tf_block_t expected_result(input tf_cmd_t c);
		tf_block_t ct;
		ct = cipher_ref(c.key, c.tweak, c.block);
		return (c.mode == TF_UBI) ? (ct ^ c.block) : ct;
	endfunction

	function automatic tf_cmd_t random_cmd(input tf_mode_e mode);
		tf_cmd_t c;
		c.mode  = mode;
		c.key   = {$urandom(), $urandom(), $urandom(), $urandom(),
			$urandom(), $urandom(), $urandom(), $urandom()};
		c.tweak = {$urandom(), $urandom(), $urandom(), $urandom()};
		c.block = {$urandom(), $urandom(), $urandom(), $urandom(),
			$urandom(), $urandom(), $urandom(), $urandom()};
		return c;
	endfunction

	task automatic check_block(input string name, input tf_block_t got, input tf_block_t exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic start_op(input tf_cmd_t c);
		@(posedge clk);
		cmd   <= c;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Counts clock edges after the start edge until done_o shows.
	task automatic wait_done(output int edges, output logic seen);
		edges = 0;
		seen  = 1'b0;
		while (!seen && edges <= OP_LIMIT) begin
			@(negedge clk);
			if (done) begin
				seen = 1'b1;
			end else begin
				check_flag("busy_o", busy, 1'b1);
				@(posedge clk);
				edges++;
			end
		end
		if (!seen) begin
			$display("done_o did not rise within %0d cycles of start", OP_LIMIT);
			errors++;
		end
	endtask

	task automatic run_check(input tf_cmd_t c);
		int   edges;
		logic seen;
		start_op(c);
		wait_done(edges, seen);
		if (seen) begin
			check_block("result_o", result, expected_result(c));
		end
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d error(s)", name, errors - errs_at_start);
		end
	endtask

	task automatic test_zero_vector();
		int errs;
		errs = errors;
		@(negedge clk);
		check_flag("done_o", done, 1'b0);
		check_flag("busy_o", busy, 1'b0);
		check_block("result_o", result, '0);
		run_check('0);
		report_test("zero_vector", errs);
	endtask

	task automatic test_random_encrypt();
		int errs;
		errs = errors;
		repeat (5) run_check(random_cmd(TF_ENCRYPT));
		report_test("random_encrypt", errs);
	endtask

	task automatic test_ubi_feed_forward();
		int errs;
		errs = errors;
		run_check(random_cmd(TF_UBI));
		report_test("ubi_feed_forward", errs);
	endtask

	task automatic test_latency_busy();
		int      errs;
		int      edges;
		logic    seen;
		tf_cmd_t c;
		errs = errors;
		c = random_cmd(TF_ENCRYPT);
		start_op(c);
		wait_done(edges, seen);
		if (seen && edges != LATENCY) begin
			$display("done_o rose %0d cycles after start, expected %0d", edges, LATENCY);
			errors++;
		end
		if (seen) begin
			check_block("result_o", result, expected_result(c));
			check_flag("busy_o", busy, 1'b1); // Still busy while done_o is high.
		end
		@(posedge clk);
		@(negedge clk);
		check_flag("done_o", done, 1'b0); // Single-cycle strobe.
		check_flag("busy_o", busy, 1'b0);
		if (seen) begin
			check_block("result_o", result, expected_result(c)); // Held after done_o.
		end
		report_test("latency_busy", errs);
	endtask

	task automatic test_start_while_busy();
		int      errs;
		int      edges;
		logic    seen;
		tf_cmd_t first;
		tf_cmd_t second;
		errs = errors;
		first  = random_cmd(TF_ENCRYPT);
		second = random_cmd(TF_UBI);
		start_op(first);
		repeat (20) @(posedge clk);
		cmd   <= random_cmd(TF_UBI);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		wait_done(edges, seen);
		if (seen) begin
			check_block("result_o", result, expected_result(first));
		end
		start_op(second); // Start lands in the cycle after done_o.
		wait_done(edges, seen);
		if (seen) begin
			check_block("result_o", result, expected_result(second));
		end
		if (seen && edges != LATENCY) begin
			$display("back-to-back start was not taken on time, done after %0d cycles", edges);
			errors++;
		end
		report_test("start_while_busy", errs);
	endtask

	task automatic test_reset_abort();
		int      errs;
		tf_cmd_t c;
		errs = errors;
		c = random_cmd(TF_UBI);
		start_op(c);
		repeat (60) @(posedge clk);
		abort_n <= 1'b0;
		@(negedge clk);
		check_flag("done_o", done, 1'b0);
		check_flag("busy_o", busy, 1'b0);
		check_block("result_o", result, '0);
		@(posedge clk);
		abort_n <= 1'b1;
		run_check(c);
		report_test("reset_abort", errs);
	endtask

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		start   = 1'b0;
		cmd     = '0;
		abort_n = 1'b1;
		void'($urandom(32'h2be91689));
		wait (arst_n === 1'b1);
		test_zero_vector();
		test_random_encrypt();
		test_ubi_feed_forward();
		test_latency_busy();
		test_start_while_busy();
		test_reset_abort();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
